/* project.f */
design/tile_pkg.sv
design/tile_bus.sv
design/mem_adapter.sv
design/local_sram.sv
design/boot_rom.sv
design/compute_tile.sv
bench/compute_tile_assert.sv
bench/compute_tile_tb.sv

/* bench/compute_tile_tb.sv */
// Compute tile testbench: clock, reset, stimulus table, port drivers, compare tasks, watchdog
module compute_tile_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import tile_pkg::*;

   typedef enum logic [1:0] {
      port_inst,
      port_data,
      port_dbg
   } port_t;

   typedef struct packed {
      port_t    port;
      logic     we;
      wb_addr_t adr;
      wb_data_t wdat;
      wb_sel_t  sel;
      wb_data_t exp_dat;
      logic     exp_err;
      logic     par;                               // Starts together with the next entry
   } entry_t;

   localparam int access_limit = 30;               // Cycles for one access, contention included
   localparam int reset_cycles = 3;

   logic     clk = 1'b0;
   logic     rst_n_i;
   wb_req_t  inst_req;
   wb_req_t  data_req;
   wb_req_t  dbg_req;
   wb_rsp_t  inst_rsp;
   wb_rsp_t  data_rsp;
   wb_rsp_t  dbg_rsp;
   logic     snoop_en;
   wb_addr_t snoop_adr;

   entry_t   stim_q [$];
   wb_data_t ref_mem [lmem_words];                 // Reference copy of the local RAM
   logic     table_ready = 1'b0;
   int       pass_count  = 0;
   int       fail_count  = 0;

   compute_tile u_compute_tile (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .inst_req_i  (inst_req),
      .data_req_i  (data_req),
      .dbg_req_i   (dbg_req),
      .inst_rsp_o  (inst_rsp),
      .data_rsp_o  (data_rsp),
      .dbg_rsp_o   (dbg_rsp),
      .snoop_en_o  (snoop_en),
      .snoop_adr_o (snoop_adr)
   );

   always #5 clk = ~clk;                           // 10 ns period

   // Expected data follows the address map: bit 31 low is RAM, region F is ROM
   function automatic void add_entry(port_t port, logic we, wb_addr_t adr, wb_sel_t sel,
                                     logic par);
      entry_t e;
      e      = '0;
      e.port = port;
      e.we   = we;
      e.adr  = adr;
      e.sel  = sel;
      e.par  = par;
      e.wdat = $urandom();
      if (port != port_dbg && adr[31:28] == 4'hf) begin
         e.exp_dat = boot_image[adr[4:2]];         // Writes leave the image alone
      end else if (port == port_dbg || adr[31] == 1'b0) begin
         for (int b = 0; b < 4; b++) begin
            if (we && sel[b]) begin
               ref_mem[adr[11:2]][8*b +: 8] = e.wdat[8*b +: 8];
            end
         end
         e.exp_dat = ref_mem[adr[11:2]];
      end else begin
         e.exp_err = 1'b1;
      end
      stim_q.push_back(e);
   endfunction

   function automatic void build_table();
      add_entry(port_data, 1'b1, 32'h0000_0100, 4'hf, 1'b0);   // RAM with byte selects
      add_entry(port_data, 1'b1, 32'h0000_0100, 4'h3, 1'b0);
      add_entry(port_data, 1'b1, 32'h0000_0104, 4'hf, 1'b0);
      add_entry(port_data, 1'b1, 32'h0000_0104, 4'ha, 1'b0);
      add_entry(port_data, 1'b0, 32'h0000_0100, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'h0000_0104, 4'hf, 1'b0);
      add_entry(port_data, 1'b1, 32'h0000_0208, 4'hf, 1'b0);
      add_entry(port_data, 1'b1, 32'h0001_0208, 4'h6, 1'b0);   // Aliases onto 0x208
      add_entry(port_data, 1'b1, 32'h0000_0208, 4'h8, 1'b0);
      add_entry(port_data, 1'b0, 32'h0000_0208, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'h7ff0_0208, 4'hf, 1'b0);
      add_entry(port_inst, 1'b0, 32'hf000_0000, 4'hf, 1'b0);   // Boot ROM
      add_entry(port_inst, 1'b0, 32'hf000_0014, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'hf000_0008, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'hfff0_003c, 4'hf, 1'b0);
      add_entry(port_data, 1'b1, 32'hf000_0008, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'hf000_0008, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'he000_0000, 4'hf, 1'b0);   // Unmapped regions
      add_entry(port_data, 1'b1, 32'he000_0010, 4'hf, 1'b0);
      add_entry(port_inst, 1'b0, 32'h8000_0000, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'hd000_0004, 4'hf, 1'b0);
      add_entry(port_data, 1'b0, 32'h0000_0100, 4'hf, 1'b0);
      add_entry(port_dbg,  1'b1, 32'h0000_0300, 4'hf, 1'b0);   // Debug and data share RAM
      add_entry(port_data, 1'b0, 32'h0000_0300, 4'hf, 1'b0);
      add_entry(port_data, 1'b1, 32'h0000_0304, 4'hf, 1'b0);
      add_entry(port_dbg,  1'b0, 32'h0000_0304, 4'hf, 1'b0);
      add_entry(port_inst, 1'b0, 32'hf000_0004, 4'hf, 1'b1);   // Contention pairs
      add_entry(port_data, 1'b0, 32'h0000_0100, 4'hf, 1'b0);
      add_entry(port_inst, 1'b0, 32'h0000_0104, 4'hf, 1'b1);
      add_entry(port_data, 1'b1, 32'h0000_0400, 4'hf, 1'b0);
      add_entry(port_dbg,  1'b1, 32'h0000_0500, 4'hf, 1'b1);
      add_entry(port_data, 1'b1, 32'h0000_0504, 4'hf, 1'b0);
      add_entry(port_dbg,  1'b0, 32'h0000_0100, 4'hf, 1'b1);
      add_entry(port_data, 1'b0, 32'h0000_0500, 4'hf, 1'b0);
      add_entry(port_dbg,  1'b0, 32'h0000_0504, 4'hf, 1'b1);
      add_entry(port_data, 1'b0, 32'h0000_0400, 4'hf, 1'b0);
   endfunction

   function automatic void drive_req(port_t port, wb_req_t req);
      case (port)
         port_inst: inst_req = req;
         port_data: data_req = req;
         default:   dbg_req  = req;
      endcase
   endfunction

   function automatic wb_rsp_t port_rsp(port_t port);
      case (port)
         port_inst: return inst_rsp;
         port_data: return data_rsp;
         default:   return dbg_rsp;
      endcase
   endfunction

   function automatic string rsp_name(port_t port);
      case (port)
         port_inst: return "inst_rsp_o";
         port_data: return "data_rsp_o";
         default:   return "dbg_rsp_o";
      endcase
   endfunction

   task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act,
                             inout int bad);
      if (act !== exp) begin
         $display("ERROR %s expected %08h got %08h", name, exp, act);
         bad++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act,
                             inout int bad);
      if (act !== exp) begin
         $display("ERROR %s expected %01h got %01h", name, exp, act);
         bad++;
      end
   endtask

   task automatic check_addr(input string name, input wb_addr_t exp, input wb_addr_t act,
                             inout int bad);
      if (act !== exp) begin
         $display("ERROR %s expected %08h got %08h", name, exp, act);
         bad++;
      end
   endtask

   // Called 1 ns after a rising edge, returns 1 ns after the edge that releases cyc
   task automatic run_entry(input int n);
      entry_t  e;
      wb_req_t req;
      wb_rsp_t rsp;
      logic    done;
      logic    exp_snoop;
      string   name;
      int      waited;
      int      bad;
      e         = stim_q[n];
      name      = rsp_name(e.port);
      exp_snoop = e.we && e.port != port_dbg && e.adr[31] == 1'b0;
      req       = '0;
      req.adr   = e.adr;
      req.dat   = e.wdat;
      req.sel   = e.sel;
      req.we    = e.we;
      req.cyc   = 1'b1;
      req.stb   = 1'b1;
      done      = 1'b0;
      waited    = 0;
      bad       = 0;
      drive_req(e.port, req);
      while (!done && waited < access_limit) begin
         @(negedge clk);                           // Outputs settled mid cycle
         rsp = port_rsp(e.port);
         if (rsp.ack || rsp.err) begin
            done = 1'b1;
            check_flag({name, ".ack"}, !e.exp_err, rsp.ack, bad);
            check_flag({name, ".err"}, e.exp_err, rsp.err, bad);
            check_flag("snoop_en_o", exp_snoop, snoop_en, bad);
            if (exp_snoop) begin
               check_addr("snoop_adr_o", e.adr, snoop_adr, bad);
            end
            if (!e.we && !e.exp_err) begin
               check_data({name, ".dat"}, e.exp_dat, rsp.dat, bad);
            end
         end
         waited++;
      end
      if (!done) begin
         $display("Test %0d got neither ack nor err on %s within %0d cycles",
                  n, name, access_limit);
         bad++;
      end
      @(posedge clk);
      #1;
      drive_req(e.port, '0);                       // Release cyc and stb
      $display("Test %0d %s %s %08h: %s", n, name, e.we ? "write" : "read", e.adr,
               bad == 0 ? "ok" : "failed");
      if (bad == 0) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   initial begin
      int n;
      int gap;
      int assert_fails;
      void'($urandom(7188));
      rst_n_i  = 1'b0;
      inst_req = '0;
      data_req = '0;
      dbg_req  = '0;
      build_table();
      table_ready = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      n = 0;
      while (n < stim_q.size()) begin
         @(posedge clk);
         #1;
         if (stim_q[n].par && n + 1 < stim_q.size()) begin
            fork
               run_entry(n);
               run_entry(n + 1);
            join
            n += 2;
         end else begin
            run_entry(n);
            n++;
         end
         gap = $urandom_range(3, 0);
         repeat (gap) @(posedge clk);
      end
      @(posedge clk);
      assert_fails = u_compute_tile.u_tile_assert.fail_total;
      $display("%0d tests passed, %0d tests failed, %0d assertion failures",
               pass_count, fail_count, assert_fails);
      if (fail_count == 0 && assert_fails == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      wait (table_ready);
      repeat (stim_q.size() * 40 + reset_cycles) @(posedge clk);
      $display("Timeout, the run did not finish within %0d cycles",
               stim_q.size() * 40 + reset_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* bench/compute_tile_assert.sv */
// Concurrent assertions on the compute tile responses and snoop output, with their bind
module compute_tile_assert (
   input logic              clk,
   input logic              rst_n_i,
   input tile_pkg::wb_rsp_t inst_rsp_i,
   input tile_pkg::wb_rsp_t data_rsp_i,
   input tile_pkg::wb_rsp_t dbg_rsp_i,
   input logic              snoop_en_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [2:0] ack_v;
   logic [2:0] err_v;
   logic [2:0] pulse_v;
   int         fail_total = 0;                     // Read by the testbench at the end

   assign ack_v   = {dbg_rsp_i.ack, data_rsp_i.ack, inst_rsp_i.ack};
   assign err_v   = {dbg_rsp_i.err, data_rsp_i.err, inst_rsp_i.err};
   assign pulse_v = ack_v | err_v;

   ack_err_excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      (ack_v & err_v) == 3'b000)
      else begin
         $error("ack and err high together on one response");
         fail_total++;
      end

   snoop_with_ack_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      snoop_en_i |-> (inst_rsp_i.ack || data_rsp_i.ack))
      else begin
         $error("snoop_en_o high without an instruction or data port ack");
         fail_total++;
      end

   single_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      (pulse_v & $past(pulse_v)) == 3'b000)
      else begin
         $error("response pulse held for two cycles");
         fail_total++;
      end

endmodule

bind compute_tile compute_tile_assert u_tile_assert (
   .clk        (clk),
   .rst_n_i    (rst_n_i),
   .inst_rsp_i (inst_rsp_o),
   .data_rsp_i (data_rsp_o),
   .dbg_rsp_i  (dbg_rsp_o),
   .snoop_en_i (snoop_en_o)
);

/* design/compute_tile.sv */
// Compute tile top level: shared bus, RAM adapter, local RAM and boot ROM
module compute_tile (
   input  logic               clk,
   input  logic               rst_n_i,
   input  tile_pkg::wb_req_t  inst_req_i,
   input  tile_pkg::wb_req_t  data_req_i,
   input  tile_pkg::wb_req_t  dbg_req_i,
   output tile_pkg::wb_rsp_t  inst_rsp_o,
   output tile_pkg::wb_rsp_t  data_rsp_o,
   output tile_pkg::wb_rsp_t  dbg_rsp_o,
   output logic               snoop_en_o,
   output tile_pkg::wb_addr_t snoop_adr_o
);
   import tile_pkg::*;

   wb_req_t bus_m_req [num_masters];
   wb_rsp_t bus_m_rsp [num_masters];
   wb_req_t ram_slv_req;
   wb_rsp_t ram_slv_rsp;
   wb_req_t rom_slv_req;
   wb_rsp_t rom_slv_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;

   // Core ports onto the bus master slots
   assign bus_m_req[0] = inst_req_i;               // Instruction port
   assign bus_m_req[1] = data_req_i;               // Data port
   assign inst_rsp_o   = bus_m_rsp[0];
   assign data_rsp_o   = bus_m_rsp[1];

   tile_bus u_bus (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .m_req_i     (bus_m_req),
      .m_rsp_o     (bus_m_rsp),
      .ram_req_o   (ram_slv_req),
      .ram_rsp_i   (ram_slv_rsp),
      .rom_req_o   (rom_slv_req),
      .rom_rsp_i   (rom_slv_rsp),
      .snoop_en_o  (snoop_en_o),
      .snoop_adr_o (snoop_adr_o)
   );

   // Debug access port shares the RAM with the bus
   mem_adapter u_mem_adapter (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .bus_req_i (ram_slv_req),
      .bus_rsp_o (ram_slv_rsp),
      .dbg_req_i (dbg_req_i),
      .dbg_rsp_o (dbg_rsp_o),
      .mem_req_o (mem_req),
      .mem_rsp_i (mem_rsp)
   );

   local_sram u_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (mem_req),
      .rsp_o   (mem_rsp)
   );

   boot_rom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (rom_slv_req),
      .rsp_o   (rom_slv_rsp)
   );

endmodule

/* design/boot_rom.sv */
// Boot ROM slave returning the boot image with a registered ack
module boot_rom (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);
   import tile_pkg::*;

   wb_data_t  rd_dat_q;
   boot_idx_t idx;
   logic      ack_q;
   logic      access;

   assign idx    = req_i.adr[boot_idx_width+1:2];  // Image repeats across region F
   assign access = req_i.cyc && req_i.stb && !ack_q;

   // Writes take the same path and are acked, the image stays as it is
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rd_dat_q <= boot_image[idx];
      end
   end

   always_comb begin
      rsp_o     = '0;
      rsp_o.dat = rd_dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

endmodule

/* design/local_sram.sv */
// Single-port local RAM slave with byte selects and registered ack
module local_sram (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);
   import tile_pkg::*;

   wb_data_t  mem [lmem_words];
   wb_data_t  rd_dat_q;
   lmem_idx_t idx;
   logic      ack_q;
   logic      access;

   assign idx = req_i.adr[lmem_idx_width+1:2];     // Wraps inside the region

   // A held stb is served again only after the ack cycle
   assign access = req_i.cyc && req_i.stb && !ack_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
               if (req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         rd_dat_q <= mem[idx];                     // Whole word, old value on a write
      end
   end

   always_comb begin
      rsp_o     = '0;
      rsp_o.dat = rd_dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;                            // Every word exists
   end

endmodule

/* design/mem_adapter.sv */
// RAM port adapter: ownership FSM between the bus slave and the debug access port
module mem_adapter (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t bus_req_i,
   output tile_pkg::wb_rsp_t bus_rsp_o,
   input  tile_pkg::wb_req_t dbg_req_i,
   output tile_pkg::wb_rsp_t dbg_rsp_o,
   output tile_pkg::wb_req_t mem_req_o,
   input  tile_pkg::wb_rsp_t mem_rsp_i
);
   import tile_pkg::*;

   mem_owner_t owner_q;
   mem_owner_t owner_d;

   // Ownership is held until the owner drops cyc.
   // The next owner is used in the same cycle, so no latency is added.
   always_comb begin
      owner_d = owner_q;
      case (owner_q)
         own_none: begin
            if (dbg_req_i.cyc) begin
               owner_d = own_dbg;                  // Debug wins a tie
            end else if (bus_req_i.cyc) begin
               owner_d = own_bus;
            end
         end
         own_bus: begin
            if (!bus_req_i.cyc) begin
               owner_d = dbg_req_i.cyc ? own_dbg : own_none;
            end
         end
         own_dbg: begin
            if (!dbg_req_i.cyc) begin
               owner_d = bus_req_i.cyc ? own_bus : own_none;
            end
         end
         default: owner_d = own_none;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner_q <= own_none;
      end else begin
         owner_q <= owner_d;
      end
   end

   // Request and response steering
   always_comb begin
      mem_req_o = '0;                              // Idle RAM port
      bus_rsp_o = '0;
      dbg_rsp_o = '0;
      case (owner_d)
         own_bus: begin
            mem_req_o = bus_req_i;
            bus_rsp_o = mem_rsp_i;
         end
         own_dbg: begin
            mem_req_o = dbg_req_i;
            dbg_rsp_o = mem_rsp_i;
         end
         default: ;                                // Waiting side sees nothing
      endcase
   end

endmodule

/* design/tile_bus.sv */
// Shared Wishbone bus: master arbitration, address decode, error responder, snoop output
module tile_bus (
   input  logic               clk,
   input  logic               rst_n_i,
   input  tile_pkg::wb_req_t  m_req_i [tile_pkg::num_masters],
   output tile_pkg::wb_rsp_t  m_rsp_o [tile_pkg::num_masters],
   output tile_pkg::wb_req_t  ram_req_o,
   input  tile_pkg::wb_rsp_t  ram_rsp_i,
   output tile_pkg::wb_req_t  rom_req_o,
   input  tile_pkg::wb_rsp_t  rom_rsp_i,
   output logic               snoop_en_o,
   output tile_pkg::wb_addr_t snoop_adr_o
);
   import tile_pkg::*;

   grant_t   grant_q;
   grant_t   grant_d;
   grant_t   grant_alt;
   wb_req_t  own_req;
   wb_rsp_t  own_rsp;
   logic     sel_ram;
   logic     sel_rom;
   logic     sel_err;
   logic     err_q;
   logic     snoop_we_q;
   wb_addr_t snoop_adr_q;

   // Arbitration
   // The owner keeps the bus as long as it holds cyc. The other master takes
   // over in the same cycle the owner lets go, so a switch costs no cycle.
   assign grant_alt = grant_q + 1'b1;              // Wraps with two masters

   always_comb begin
      grant_d = grant_q;
      if (!m_req_i[grant_q].cyc && m_req_i[grant_alt].cyc) begin
         grant_d = grant_alt;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         grant_q <= '0;                            // Instruction port first
      end else begin
         grant_q <= grant_d;
      end
   end

   assign own_req = m_req_i[grant_d];

   // Address decode
   assign sel_ram = own_req.adr[$bits(wb_addr_t)-1 -: ram_match_width] == ram_match;
   assign sel_rom = own_req.adr[$bits(wb_addr_t)-1 -: rom_match_width] == rom_match;
   assign sel_err = !sel_ram && !sel_rom;          // Includes region E

   always_comb begin
      ram_req_o     = own_req;
      ram_req_o.cyc = own_req.cyc && sel_ram;      // Only the hit slave sees the cycle
      ram_req_o.stb = own_req.stb && sel_ram;
      rom_req_o     = own_req;
      rom_req_o.cyc = own_req.cyc && sel_rom;
      rom_req_o.stb = own_req.stb && sel_rom;
   end

   // Error responder with the same pulse timing as the memories
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= own_req.cyc && own_req.stb && sel_err && !err_q;
      end
   end

   // Response path back to the owner
   always_comb begin
      own_rsp = '0;
      if (sel_ram) begin
         own_rsp = ram_rsp_i;
      end else if (sel_rom) begin
         own_rsp = rom_rsp_i;
      end else begin
         own_rsp.err = err_q;
      end
   end

   always_comb begin
      for (int m = 0; m < num_masters; m++) begin
         m_rsp_o[m] = '0;
         if (grant_d == grant_t'(m)) begin
            m_rsp_o[m] = own_rsp;
         end
      end
   end

   // Snoop
   // The write is captured while it is presented to the RAM slave, and the
   // pulse is released by the RAM ack that completes it. The adapter gates
   // the ack while the debug port owns the RAM, so debug writes never snoop.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         snoop_we_q <= 1'b0;
      end else if (ram_req_o.cyc && ram_req_o.stb) begin
         snoop_we_q <= ram_req_o.we;
      end
   end

   always_ff @(posedge clk) begin
      if (ram_req_o.cyc && ram_req_o.stb) begin
         snoop_adr_q <= ram_req_o.adr;
      end
   end

   assign snoop_en_o  = ram_rsp_i.ack && snoop_we_q;
   assign snoop_adr_o = snoop_adr_q;

endmodule

/* design/tile_pkg.sv */
// Bus widths, address map, memory sizes, Wishbone request and response structs, boot image
package tile_pkg;

   // Bus vectors
   typedef logic [31:0] wb_addr_t;                // Byte address
   typedef logic [31:0] wb_data_t;                // Data word
   typedef logic [3:0]  wb_sel_t;                 // One select per byte

   // Classic cycle master request, no burst signals
   typedef struct packed {
      wb_addr_t adr;
      wb_data_t dat;
      wb_sel_t  sel;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   // Slave response
   typedef struct packed {
      wb_data_t dat;
      logic     ack;                               // Single cycle pulse
      logic     err;                               // Never together with ack
   } wb_rsp_t;

   // Masters: 0 is the instruction port, 1 the data port
   localparam int num_masters = 2;
   typedef logic [$clog2(num_masters)-1:0] grant_t;

   // Address map, matched on the upper address bits
   localparam int                         ram_match_width = 1;
   localparam logic [ram_match_width-1:0] ram_match       = 1'b0;    // Lower half
   localparam int                         rom_match_width = 4;
   localparam logic [rom_match_width-1:0] rom_match       = 4'hf;    // Region F

   // Local RAM, word index taken from address bits 11:2
   localparam int lmem_words     = 1024;
   localparam int lmem_idx_width = $clog2(lmem_words);
   typedef logic [lmem_idx_width-1:0] lmem_idx_t;

   // Boot ROM, word index taken from address bits 4:2
   localparam int boot_words     = 8;
   localparam int boot_idx_width = $clog2(boot_words);
   typedef logic [boot_idx_width-1:0] boot_idx_t;

   // Sets up a stack pointer and jumps to the start of local RAM
   localparam wb_data_t boot_image [boot_words] = '{
      32'h18200000,                                // l.movhi r1,0x0000
      32'ha8210ffc,                                // l.ori r1,r1,0x0ffc
      32'h18600000,                                // l.movhi r3,0x0000
      32'ha8630100,                                // l.ori r3,r3,0x0100
      32'h44001800,                                // l.jr r3
      32'h15000000,                                // Delay slot
      32'h15000001,
      32'h00000000                                 // Never reached
   };

   // Ownership of the single RAM port
   typedef enum logic [1:0] {
      own_none,
      own_bus,
      own_dbg
   } mem_owner_t;

endpackage
